/* logic/btb_pkg.sv */
// branch target predictor shared definitions
// widths, reset address and the structs passed between the
// table ways, the return stack and the fetch pc unit
package btb_pkg;

  // ==============================
  // address and fetch group sizes
  // ==============================
  parameter int unsigned PC_W        = 32;  // one fetch address word
  parameter int unsigned FETCH_WIDTH = 4;   // insns per group, also number of ways
  parameter int unsigned INSN_BYTES  = 6;   // bytes per instruction

  typedef logic [PC_W-1:0] pc_t;

  parameter pc_t RESET_PC = 32'hFFFC0000;  // fetch starts here after reset

  // ==============================
  // table entry and commit group
  // ==============================

  // one btb entry, also one slot of a commit group
  typedef struct packed {
    logic takb;  // branch was taken
    pc_t  pc;    // branch address, full tag
    pc_t  tgt;   // branch target
  } btb_entry_t;

  // slot 0 supplies the table index for the whole group
  typedef btb_entry_t [FETCH_WIDTH-1:0] commit_group_t;

  // ==============================
  // flow change request
  // ==============================
  typedef struct packed {
    logic valid;  // request present this cycle
    pc_t  tgt;    // where fetch goes
  } redirect_t;

endpackage

/* logic/btb_ways.sv */
`timescale 1ns/100ps
// branch target table ways
// FETCH_WIDTH tables, one per slot of the fetch group
// commit groups go through a one cycle staging register, then
// the taken slots are written at the index of slot 0
// lookup reads every way at the fetch pc index, no clock delay
module btb_ways
  import btb_pkg::*;
#(
  parameter int unsigned BTB_DEPTH = 256  // entries per way, power of two
) (
  input  logic                   clk,
  input  logic                   rst,
  input  pc_t                    pc,            // current fetch group address
  input  commit_group_t          commit,        // committed group from the back end
  input  logic                   commit_valid,
  output logic [FETCH_WIDTH-1:0] hit,           // slot i predicted taken
  output pc_t  [FETCH_WIDTH-1:0] hit_tgt        // target per way
);

  localparam int unsigned IDX_W = $clog2(BTB_DEPTH);

  typedef logic [IDX_W-1:0] idx_t;

  // ==============================
  // commit staging
  // ==============================
  commit_group_t          stg_grp;  // payload, one cycle behind commit
  idx_t                   stg_idx;  // write index from slot 0
  logic [FETCH_WIDTH-1:0] stg_we;   // per way write enable

  // lookup side
  idx_t                         rd_idx;
  btb_entry_t [FETCH_WIDTH-1:0] rd_entry;

  assign rd_idx = pc[IDX_W:1];  // bit 0 never distinguishes groups

  // write enables are control state and get cleared
  always_ff @(posedge clk) begin
    if (rst) begin
      stg_we <= '0;
    end else begin
      for (int i = 0; i < FETCH_WIDTH; i++) begin
        stg_we[i] <= commit_valid & commit[i].takb;  // only taken slots land
      end
    end
  end

  always_ff @(posedge clk) begin
    stg_grp <= commit;
    stg_idx <= commit[0].pc[IDX_W:1];  // whole group shares slot 0 index
  end

  // ==============================
  // ways
  // ==============================
  for (genvar w = 0; w < FETCH_WIDTH; w++) begin : g_way
    btb_entry_t tbl [BTB_DEPTH];  // entry storage for this slot
    pc_t        slot_pc;          // address of slot w in the fetch group

    always_ff @(posedge clk) begin
      if (rst) begin
        for (int e = 0; e < BTB_DEPTH; e++) begin
          tbl[e] <= '0;  // empty table, nothing hits
        end
      end else if (stg_we[w]) begin
        tbl[stg_idx] <= stg_grp[w];
      end
    end

    assign rd_entry[w] = tbl[rd_idx];

    // tag is the full branch address of the slot
    assign slot_pc    = pc + pc_t'(w * INSN_BYTES);
    assign hit[w]     = rd_entry[w].takb & (rd_entry[w].pc == slot_pc);
    assign hit_tgt[w] = rd_entry[w].tgt;
  end

endmodule

/* logic/return_stack.sv */
`timescale 1ns/100ps
// return address stack
// a call pushes ret_pc, a return pops, both together do nothing
// the stack grows downward and the pointer wraps at RAS_DEPTH
// ret_addr shows the top entry before any pop at the edge
module return_stack
  import btb_pkg::*;
#(
  parameter int unsigned RAS_DEPTH = 32
) (
  input  logic clk,
  input  logic rst,
  input  logic do_call,   // push this cycle
  input  logic do_ret,    // pop this cycle
  input  pc_t  ret_pc,    // return address of the call
  output pc_t  ret_addr   // current top of stack
);

  localparam int unsigned SP_W = $clog2(RAS_DEPTH);

  typedef logic [SP_W-1:0] sp_t;

  pc_t  ras [RAS_DEPTH];  // return addresses
  sp_t  sp;               // points at the top entry
  sp_t  sp_dn;            // slot a push lands in
  logic push;
  logic pop;

  assign push  = do_call & ~do_ret;
  assign pop   = do_ret & ~do_call;
  assign sp_dn = sp - sp_t'(1);  // wraps below zero

  // ==============================
  // pointer and entries
  // ==============================
  always_ff @(posedge clk) begin
    if (rst) begin
      sp <= '0;
    end else if (push) begin
      sp <= sp_dn;
    end else if (pop) begin
      sp <= sp + sp_t'(1);  // wraps past the top
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int j = 0; j < RAS_DEPTH; j++) begin
        ras[j] <= RESET_PC;  // defined value on an empty pop
      end
    end else if (push) begin
      ras[sp_dn] <= ret_pc;
    end
  end

  assign ret_addr = ras[sp];

endmodule

/* logic/fetch_pc_unit.sv */
`timescale 1ns/100ps
// fetch pc unit
// fixed priority choice of the next fetch address over the
// interrupt, return, correction and miss requests, then the
// lowest hitting table way, then the sequential group step
// holds the fetch pc register, loaded on advance_pc
module fetch_pc_unit
  import btb_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   en,           // allow table predictions
  input  logic                   advance_pc,   // load next_pc this cycle
  input  redirect_t              nmi_req,
  input  redirect_t              irq_req,
  input  redirect_t              excret_req,   // exception return
  input  redirect_t              dec_fix_req,  // decode stage correction
  input  redirect_t              mux_fix_req,  // mux stage override
  input  redirect_t              bsr_req,      // bsr / jsr target
  input  redirect_t              miss_req,     // branch miss
  input  logic                   do_ret,
  input  pc_t                    ret_addr,     // top of return stack
  input  logic [FETCH_WIDTH-1:0] hit,
  input  pc_t  [FETCH_WIDTH-1:0] hit_tgt,
  output pc_t                    pc,
  output pc_t                    next_pc,
  output logic [FETCH_WIDTH-1:0] takb          // one hot, chosen way
);

  localparam int unsigned GROUP_BYTES = FETCH_WIDTH * INSN_BYTES;
  localparam int unsigned WAY_W       = $clog2(FETCH_WIDTH);

  typedef logic [WAY_W-1:0] way_t;

  way_t way_sel;  // lowest hitting way
  logic way_hit;  // some way hits

  // ==============================
  // lowest way pick
  // ==============================
  always_comb begin
    way_sel = '0;
    way_hit = 1'b0;
    // scan from the top so the lowest hit is left standing
    for (int i = FETCH_WIDTH - 1; i >= 0; i--) begin
      if (hit[i]) begin
        way_sel = way_t'(i);
        way_hit = 1'b1;
      end
    end
  end

  // ==============================
  // next pc priority
  // ==============================
  always_comb begin
    next_pc = pc + pc_t'(GROUP_BYTES);  // default, next sequential group
    takb    = '0;
    if (nmi_req.valid) begin
      next_pc = nmi_req.tgt;
    end else if (irq_req.valid) begin
      next_pc = irq_req.tgt;
    end else if (excret_req.valid) begin
      next_pc = excret_req.tgt;
    end else if (do_ret) begin
      next_pc = ret_addr;              // popped return address
    end else if (dec_fix_req.valid) begin
      next_pc = dec_fix_req.tgt;       // decode beats mux stage
    end else if (mux_fix_req.valid) begin
      next_pc = mux_fix_req.tgt;
    end else if (bsr_req.valid) begin
      next_pc = bsr_req.tgt;
    end else if (miss_req.valid) begin
      next_pc = miss_req.tgt;
    end else if (en && way_hit) begin
      next_pc       = hit_tgt[way_sel];
      takb[way_sel] = 1'b1;            // record taken slot
    end
  end

  // fetch pc, holds while advance_pc is low
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (advance_pc) begin
      pc <= next_pc;
    end
  end

endmodule

/* logic/branch_target_predictor.sv */
`timescale 1ns/100ps
// branch target predictor, top level
// ties the table ways, the return stack and the fetch pc unit
// together; the fetch pc feeds the lookup and the hits come back
// to the priority selection
module branch_target_predictor
  import btb_pkg::*;
#(
  parameter int unsigned BTB_DEPTH = 256,
  parameter int unsigned RAS_DEPTH = 32
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   en,
  input  logic                   advance_pc,
  input  redirect_t              nmi_req,
  input  redirect_t              irq_req,
  input  redirect_t              excret_req,
  input  redirect_t              dec_fix_req,
  input  redirect_t              mux_fix_req,
  input  redirect_t              bsr_req,
  input  redirect_t              miss_req,
  input  logic                   do_call,
  input  pc_t                    ret_pc,
  input  logic                   do_ret,
  input  commit_group_t          commit,
  input  logic                   commit_valid,
  output pc_t                    pc,
  output pc_t                    next_pc,
  output logic [FETCH_WIDTH-1:0] takb
);

  logic [FETCH_WIDTH-1:0] hit;       // per way prediction
  pc_t  [FETCH_WIDTH-1:0] hit_tgt;
  pc_t                    ret_addr;  // top of return stack

  btb_ways #(
    .BTB_DEPTH (BTB_DEPTH)
  ) u_ways (
    .clk          (clk),
    .rst          (rst),
    .pc           (pc),
    .commit       (commit),
    .commit_valid (commit_valid),
    .hit          (hit),
    .hit_tgt      (hit_tgt)
  );

  return_stack #(
    .RAS_DEPTH (RAS_DEPTH)
  ) u_ras (
    .clk      (clk),
    .rst      (rst),
    .do_call  (do_call),
    .do_ret   (do_ret),
    .ret_pc   (ret_pc),
    .ret_addr (ret_addr)
  );

  fetch_pc_unit u_fpc (
    .clk         (clk),
    .rst         (rst),
    .en          (en),
    .advance_pc  (advance_pc),
    .nmi_req     (nmi_req),
    .irq_req     (irq_req),
    .excret_req  (excret_req),
    .dec_fix_req (dec_fix_req),
    .mux_fix_req (mux_fix_req),
    .bsr_req     (bsr_req),
    .miss_req    (miss_req),
    .do_ret      (do_ret),
    .ret_addr    (ret_addr),
    .hit         (hit),
    .hit_tgt     (hit_tgt),
    .pc          (pc),
    .next_pc     (next_pc),
    .takb        (takb)
  );

endmodule

/* dv/btb_assertions.sv */
`timescale 1ns/100ps
// branch target predictor checker
// concurrent properties on the top level outputs: takb one hot or
// zero, no prediction while en is low, and pc follows next_pc
// whenever advance_pc was high at the previous edge
module btb_assertions
  import btb_pkg::*;
(
  input logic                   clk,
  input logic                   rst,
  input logic                   en,
  input logic                   advance_pc,
  input pc_t                    pc,
  input pc_t                    next_pc,
  input logic [FETCH_WIDTH-1:0] takb
);

  int fail_cnt = 0;  // assertion failures so far

  // ==============================
  // prediction shape
  // ==============================
  a_takb_onehot0: assert property (@(posedge clk) disable iff (rst)
    $onehot0(takb))
    else begin
      fail_cnt++;
      $error("takb has more than one way bit set");
    end

  a_takb_en: assert property (@(posedge clk) disable iff (rst)
    !en |-> (takb == '0))  // table predictions gated by en
    else begin
      fail_cnt++;
      $error("takb is set while en is low");
    end

  // ==============================
  // fetch pc load
  // ==============================
  a_pc_load: assert property (@(posedge clk) disable iff (rst)
    (!$past(rst) && $past(advance_pc)) |-> (pc == $past(next_pc)))
    else begin
      fail_cnt++;
      $error("pc did not load the previous next_pc");
    end

endmodule

bind branch_target_predictor btb_assertions u_assertions (
  .clk        (clk),
  .rst        (rst),
  .en         (en),
  .advance_pc (advance_pc),
  .pc         (pc),
  .next_pc    (next_pc),
  .takb       (takb)
);

/* dv/tb_branch_target_predictor.sv */
`timescale 1ns/100ps
// testbench for the branch target predictor
// random redirects, calls, returns and commit groups drawn from a
// pool of 16 group addresses, checked every cycle against a model
// of the staged tables, the return stack and the priority rule
module tb_branch_target_predictor
  import btb_pkg::*;
();

  localparam int unsigned BTB_DEPTH    = 256;
  localparam int unsigned RAS_DEPTH    = 32;
  localparam int unsigned IDX_W        = $clog2(BTB_DEPTH);
  localparam int unsigned SP_W         = $clog2(RAS_DEPTH);
  localparam int unsigned GROUP_BYTES  = FETCH_WIDTH * INSN_BYTES;  // 24
  localparam int          PERIOD       = 20;
  localparam int          RESET_CYCLES = 10;
  localparam int          QUIET_CYCLES = 12;    // 8 stepping then 4 holding
  localparam int          CYCLES       = 3000;
  localparam int          WATCHDOG_NS  = (RESET_CYCLES + QUIET_CYCLES + CYCLES) * PERIOD * 2;
  localparam pc_t         POOL_BASE    = 32'h0001_0000;
  localparam int          MODE_STEP    = 0;
  localparam int          MODE_HOLD    = 1;
  localparam int          MODE_RAND    = 2;

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [SP_W-1:0]  sp_t;

  logic clk, rst, en, advance_pc, do_call, do_ret, commit_valid;
  redirect_t nmi_req, irq_req, excret_req, dec_fix_req, mux_fix_req, bsr_req, miss_req;
  pc_t ret_pc, pc, next_pc;
  commit_group_t commit;
  logic [FETCH_WIDTH-1:0] takb;

  // ==============================
  // reference model state
  // ==============================
  btb_entry_t             m_tbl [FETCH_WIDTH][BTB_DEPTH];
  commit_group_t          m_stg;      // staged commit group
  idx_t                   m_stg_idx;
  logic [FETCH_WIDTH-1:0] m_stg_we;
  pc_t                    m_ras [RAS_DEPTH];
  sp_t                    m_sp;
  pc_t                    m_pc;
  pc_t                    exp_next;   // expected this cycle
  logic [FETCH_WIDTH-1:0] exp_takb;
  int                     seed, err_pc, err_next, err_takb;

  branch_target_predictor #(
    .BTB_DEPTH (BTB_DEPTH),
    .RAS_DEPTH (RAS_DEPTH)
  ) UUT (.*);

  always #(PERIOD / 2) clk = ~clk;

  function automatic int unsigned rnd();
    rnd = $unsigned($random(seed));
  endfunction

  // pool entries k and k+8 share a table index but not a tag
  function automatic pc_t pool_addr();
    int unsigned k;
    k = rnd() % 16;
    return POOL_BASE + pc_t'((k % 8) * 48) + pc_t'((k / 8) * 32'h200);
  endfunction

  function automatic redirect_t draw_redirect();
    redirect_t r;
    r.valid = (rnd() % 100) < 5;  // about 5% of cycles
    r.tgt   = pool_addr();
    return r;
  endfunction

  task automatic clear_inputs();
    {en, advance_pc, do_call, do_ret, commit_valid} = '0;
    {nmi_req, irq_req, excret_req, dec_fix_req} = '0;
    {mux_fix_req, bsr_req, miss_req} = '0;
    ret_pc = '0;
    commit = '0;
  endtask

  task automatic drive_random();
    pc_t base;
    en          = (rnd() % 8) != 0;
    advance_pc  = (rnd() % 8) != 0;
    nmi_req     = draw_redirect();
    irq_req     = draw_redirect();
    excret_req  = draw_redirect();
    dec_fix_req = draw_redirect();
    mux_fix_req = draw_redirect();
    bsr_req     = draw_redirect();
    miss_req    = draw_redirect();
    do_call     = (rnd() % 10) == 0;  // calls outnumber returns so sp wraps
    do_ret      = (rnd() % 16) == 0;
    ret_pc      = pool_addr();
    commit_valid = (rnd() % 4) == 0;
    base = pool_addr();
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      commit[i].takb = (rnd() % 2) == 1;
      commit[i].pc   = base + pc_t'(i * INSN_BYTES);  // slot address
      commit[i].tgt  = pool_addr();
    end
  endtask

  task automatic reset_model();
    for (int w = 0; w < FETCH_WIDTH; w++) begin
      for (int e = 0; e < BTB_DEPTH; e++) begin
        m_tbl[w][e] = '0;
      end
    end
    for (int j = 0; j < RAS_DEPTH; j++) begin
      m_ras[j] = RESET_PC;
    end
    m_stg_we = '0;
    m_sp     = '0;
    m_pc     = RESET_PC;
  endtask

  // ==============================
  // priority rule and lookup
  // ==============================
  task automatic predict();
    btb_entry_t e;
    logic       found;
    found    = 1'b0;
    exp_takb = '0;
    exp_next = m_pc + pc_t'(GROUP_BYTES);
    if (nmi_req.valid) exp_next = nmi_req.tgt;
    else if (irq_req.valid) exp_next = irq_req.tgt;
    else if (excret_req.valid) exp_next = excret_req.tgt;
    else if (do_ret) exp_next = m_ras[m_sp];
    else if (dec_fix_req.valid) exp_next = dec_fix_req.tgt;
    else if (mux_fix_req.valid) exp_next = mux_fix_req.tgt;
    else if (bsr_req.valid) exp_next = bsr_req.tgt;
    else if (miss_req.valid) exp_next = miss_req.tgt;
    else if (en) begin
      for (int i = 0; i < FETCH_WIDTH; i++) begin
        e = m_tbl[i][idx_t'(m_pc[IDX_W:1])];
        if (!found && e.takb && e.pc == m_pc + pc_t'(i * INSN_BYTES)) begin
          found       = 1'b1;  // lowest way wins
          exp_next    = e.tgt;
          exp_takb[i] = 1'b1;
        end
      end
    end
  endtask

  task automatic check_outputs();
    if (pc !== m_pc) begin
      $display("error: pc got %h expected %h", pc, m_pc);
      err_pc++;
    end
    if (next_pc !== exp_next) begin
      $display("error: next_pc got %h expected %h", next_pc, exp_next);
      err_next++;
    end
    if (takb !== exp_takb) begin
      $display("error: takb got %h expected %h", takb, exp_takb);
      err_takb++;
    end
  endtask

  // state change at a rising edge with the staged write landing before the capture
  task automatic advance_model();
    for (int w = 0; w < FETCH_WIDTH; w++) begin
      if (m_stg_we[w]) m_tbl[w][m_stg_idx] = m_stg[w];
      m_stg_we[w] = commit_valid & commit[w].takb;
    end
    m_stg     = commit;
    m_stg_idx = idx_t'(commit[0].pc[IDX_W:1]);
    if (advance_pc) m_pc = exp_next;
    if (do_call && !do_ret) begin
      m_sp        = m_sp - sp_t'(1);
      m_ras[m_sp] = ret_pc;
    end else if (do_ret && !do_call) begin
      m_sp = m_sp + sp_t'(1);
    end
  endtask

  // entered and left at a falling edge
  task automatic run_cycle(input int mode);
    if (mode == MODE_RAND) begin
      drive_random();
    end else begin
      clear_inputs();
      en         = 1'b1;
      advance_pc = (mode == MODE_STEP);
    end
    #(PERIOD / 4);  // outputs settled well clear of the edge
    predict();
    check_outputs();
    @(posedge clk);
    advance_model();
    @(negedge clk);
  endtask

  // ==============================
  // main sequence and watchdog
  // ==============================
  initial begin
    clk      = 1'b0;
    seed     = 32'h6325;
    err_pc   = 0;
    err_next = 0;
    err_takb = 0;
    clear_inputs();
    rst = 1'b1;
    reset_model();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int n = 0; n < QUIET_CYCLES; n++) begin
      run_cycle(n < 8 ? MODE_STEP : MODE_HOLD);  // step then hold with empty tables
    end
    for (int n = 0; n < CYCLES; n++) begin
      run_cycle(MODE_RAND);
    end
    $display("done: pc errors %0d, next_pc errors %0d, takb errors %0d, assertion errors %0d",
             err_pc, err_next, err_takb, UUT.u_assertions.fail_cnt);
    if (err_pc + err_next + err_takb + UUT.u_assertions.fail_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* branch_target_predictor.f */
logic/btb_pkg.sv
logic/btb_ways.sv
logic/return_stack.sv
logic/fetch_pc_unit.sv
logic/branch_target_predictor.sv
dv/btb_assertions.sv
dv/tb_branch_target_predictor.sv

/* run.sh */
#!/bin/sh
# compile the branch target predictor testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_branch_target_predictor \
  -f branch_target_predictor.f

out=$(./obj_dir/Vtb_branch_target_predictor)
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1
